// File: files.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/uop_pkg.sv
hdl/decode_lane.sv
hdl/bundle_packer.sv
hdl/issue_buffer.sv
hdl/decode_top.sv
bench/decode_clock_gen.sv
bench/decode_properties.sv
bench/tb_decode.sv

// File: run_sim.sh
#!/bin/sh
# builds the decode testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_decode -f files.f -o tb_decode_sim

./obj_dir/tb_decode_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "run ended without a result line"
    exit 1
fi
exit 0

// File: bench/tb_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module tb_decode;

    localparam int NUM_ROWS = 12;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 20;
    localparam int CNT_W = $clog2(`DEC_BUNDLE_WIDTH + 1);

    logic clk_in, rst_n, flush, fetch_valid, decode_ready, out_valid, exe_ready;
    logic [1:0] fetch_count, predict_taken;
    logic [`DEC_PC_WIDTH-1:0] fetch_pc;
    isa_pkg::insn_t fetch_words [`DEC_FETCH_WIDTH];
    uop_pkg::bundle_t out_bundle;

    logic [31:0] row_w0 [NUM_ROWS];
    logic [31:0] row_w1 [NUM_ROWS];
    logic [1:0]  row_cnt [NUM_ROWS];
    logic [1:0]  row_pred [NUM_ROWS];
    logic [63:0] row_pc [NUM_ROWS];
    uop_pkg::bundle_t row_exp [NUM_ROWS];
    uop_pkg::bundle_t exp_q [$];
    int nrows = 0;
    int value_errors = 0;
    int other_errors = 0;
    int ready_mode = 0;  // 0 random, 1 always ready, 2 stalled
    integer seed = 32'h78c5;

    decode_clock_gen i_clock_gen (.clk_in(clk_in), .rst_n(rst_n));

    decode_top i_decode_top (
        .clk_in(clk_in), .rst_n(rst_n), .flush(flush),
        .fetch_valid(fetch_valid), .fetch_count(fetch_count),
        .fetch_words(fetch_words), .fetch_pc(fetch_pc),
        .predict_taken(predict_taken), .decode_ready(decode_ready),
        .out_valid(out_valid), .out_bundle(out_bundle), .exe_ready(exe_ready)
    );

    // instruction encoders, opcode in 31:24
    function automatic logic [31:0] enc_ri(input logic [7:0] op, input logic [11:0] imm12,
                                           input logic [4:0] rn, input logic [4:0] rd);
        return {op, 2'b00, imm12, rn, rd};
    endfunction

    function automatic logic [31:0] enc_rr(input logic [7:0] op, input logic [4:0] rm,
                                           input logic [4:0] rn, input logic [4:0] rd);
        return {op, 3'b000, rm, 6'd0, rn, rd};
    endfunction

    function automatic logic [31:0] enc_mem(input logic [7:0] op, input logic [8:0] imm9,
                                            input logic [4:0] rn, input logic [4:0] rd);
        return {op, 3'b000, imm9, 2'b00, rn, rd};
    endfunction

    function automatic uop_pkg::reg_ref_t gpr(input logic [4:0] n);
        return {n, 1'b0};
    endfunction

    // flags are {valb_sel, mem_read, mem_write, w_enable, tx_begin, tx_end}
    function automatic uop_pkg::uop_t make_uop(input uop_pkg::uop_code_e code,
            input uop_pkg::reg_ref_t dst, input uop_pkg::reg_ref_t src1,
            input uop_pkg::reg_ref_t src2, input logic [20:0] imm, input logic [1:0] hw,
            input logic [5:0] flags, input logic [63:0] pc);
        uop_pkg::uop_t u;
        u = '0;
        u.code = code;
        u.dst = dst;
        u.src1 = src1;
        u.src2 = src2;
        u.imm = imm;
        u.hw = hw;
        {u.valb_sel, u.mem_read, u.mem_write, u.w_enable, u.tx_begin, u.tx_end} = flags;
        u.pc = pc;
        return u;
    endfunction

    task automatic add_row(input logic [31:0] w0, input logic [31:0] w1,
                           input logic [1:0] cnt, input logic [63:0] pc, input logic [1:0] pred);
        row_w0[nrows] = w0;
        row_w1[nrows] = w1;
        row_cnt[nrows] = cnt;
        row_pc[nrows] = pc;
        row_pred[nrows] = pred;
        row_exp[nrows] = '0;
        nrows++;
    endtask

    task automatic add_uop(input uop_pkg::uop_t u);
        row_exp[nrows-1].uops[row_exp[nrows-1].count] = u;
        row_exp[nrows-1].count = row_exp[nrows-1].count + 1'b1;
    endtask

    task automatic check_uop(input uop_pkg::uop_t got, input uop_pkg::uop_t exp, input int slot);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: uop %0d got %h expected %h", $time, slot, got, exp);
        end
    endtask

    task automatic check_count(input logic [CNT_W-1:0] got, input logic [CNT_W-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: bundle count %0d expected %0d", $time, got, exp);
        end
    endtask

    // drives a row and holds it until decode_ready is seen on an edge
    task automatic offer_row(input int r, input bit track);
        bit accepted;
        fetch_valid = 1'b1;
        fetch_words[0] = row_w0[r];
        fetch_words[1] = row_w1[r];
        fetch_count = row_cnt[r];
        fetch_pc = row_pc[r];
        predict_taken = row_pred[r];
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk_in);
            accepted = decode_ready;
        end
        if (track && row_exp[r].count != '0)
            exp_q.push_back(row_exp[r]);
        #2;
        fetch_valid = 1'b0;
    endtask

    initial begin
        flush = 1'b0;
        fetch_valid = 1'b0;
        fetch_count = 2'd0;
        fetch_words[0] = '0;
        fetch_words[1] = '0;
        fetch_pc = '0;
        predict_taken = 2'b00;
        exe_ready = 1'b0;
    end

    always @(posedge clk_in) begin
        #2;
        if (ready_mode == 2)
            exe_ready = 1'b0;
        else if (ready_mode == 1)
            exe_ready = 1'b1;
        else
            exe_ready = 1'($random(seed));
    end

    always @(posedge clk_in) begin
        if (rst_n && out_valid && exe_ready) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("a bundle came out at %0t with nothing left to expect", $time);
            end else begin
                uop_pkg::bundle_t exp;
                exp = exp_q.pop_front();
                check_count(out_bundle.count, exp.count);
                for (int i = 0; i < `DEC_BUNDLE_WIDTH; i++)
                    check_uop(out_bundle.uops[i], exp.uops[i], i);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 40);
        $display("watchdog expired after %0d cycles, the DUT stopped making progress",
                 WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        uop_pkg::reg_ref_t sp;
        uop_pkg::reg_ref_t none;
        int assert_errors;
        sp = {5'd31, 1'b1};
        none = '0;
        add_row(enc_ri(`DEC_OP_ADD_I, 12'h010, 5'd31, 5'd1),
                enc_ri(`DEC_OP_SUB_I, 12'h008, 5'd31, 5'd31), 2'd2, 64'h1000, 2'b00);
        add_uop(make_uop(uop_pkg::UOP_ADD, gpr(1), sp, none, 21'h10, 2'd0, 6'b000111, 64'h1000));
        add_uop(make_uop(uop_pkg::UOP_SUB, sp, sp, none, 21'h8, 2'd0, 6'b000111, 64'h1004));
        add_row(enc_rr(`DEC_OP_ADDS, 5'd5, 5'd4, 5'd3),
                enc_rr(`DEC_OP_ORR, 5'd8, 5'd7, 5'd6), 2'd2, 64'h1008, 2'b00);
        add_uop(make_uop(uop_pkg::UOP_ADD, gpr(3), gpr(4), gpr(5), 0, 2'd0, 6'b100111, 64'h1008));
        add_uop(make_uop(uop_pkg::UOP_ORR, gpr(6), gpr(7), gpr(8), 0, 2'd0, 6'b100111, 64'h100c));
        // cracked load then a store that keeps its offset
        add_row(enc_mem(`DEC_OP_LDUR, 9'h020, 5'd9, 5'd2),
                enc_mem(`DEC_OP_STUR, 9'h004, 5'd11, 5'd10), 2'd2, 64'h1010, 2'b00);
        add_uop(make_uop(uop_pkg::UOP_ADD, gpr(2), gpr(9), none, 21'h20, 2'd0, 6'b000110, 64'h1010));
        add_uop(make_uop(uop_pkg::UOP_LOAD, gpr(2), gpr(2), none, 0, 2'd0, 6'b010101, 64'h1010));
        add_uop(make_uop(uop_pkg::UOP_STORE, none, gpr(11), gpr(10), 21'h4, 2'd0, 6'b001011,
                         64'h1014));
        add_row(enc_mem(`DEC_OP_LDUR, 9'h000, 5'd13, 5'd12),
                enc_ri(`DEC_OP_ADD_I, 12'h003, 5'd5, 5'd31), 2'd2, 64'h1018, 2'b00);
        add_uop(make_uop(uop_pkg::UOP_LOAD, gpr(12), gpr(13), none, 0, 2'd0, 6'b010111, 64'h1018));
        add_uop(make_uop(uop_pkg::UOP_ADD, gpr(31), gpr(5), none, 21'h3, 2'd0, 6'b000111, 64'h101c));
        add_row({`DEC_OP_B, 24'h000010},
                enc_rr(`DEC_OP_SUBS, 5'd1, 5'd2, 5'd3), 2'd2, 64'h1020, 2'b00);
        add_row({`DEC_OP_BCOND, 24'h000040},
                enc_rr(`DEC_OP_EOR, 5'd3, 5'd2, 5'd1), 2'd2, 64'h1028, 2'b01);
        add_uop(make_uop(uop_pkg::UOP_BCOND, none, none, none, 0, 2'd0, 6'b000011, 64'h1028));
        add_row({`DEC_OP_BCOND, 24'h000040},
                enc_rr(`DEC_OP_EOR, 5'd3, 5'd2, 5'd1), 2'd2, 64'h1030, 2'b10);
        add_uop(make_uop(uop_pkg::UOP_BCOND, none, none, none, 0, 2'd0, 6'b000011, 64'h1030));
        add_uop(make_uop(uop_pkg::UOP_EOR, gpr(1), gpr(2), gpr(3), 0, 2'd0, 6'b100111, 64'h1034));
        add_row({`DEC_OP_NOP, 24'h0}, {`DEC_OP_NOP, 24'h0}, 2'd2, 64'h1038, 2'b00);
        add_row(enc_ri(`DEC_OP_ADD_I, 12'h001, 5'd1, 5'd1), 32'h0, 2'd0, 64'h103c, 2'b00);
        add_row({`DEC_OP_MOVK, 1'b0, 2'd2, 16'hbeef, 5'd7},
                {`DEC_OP_HLT, 24'h0}, 2'd2, 64'h1040, 2'b00);
        add_uop(make_uop(uop_pkg::UOP_MOVK, gpr(7), none, none, 21'hbeef, 2'd2, 6'b000111,
                         64'h1040));
        add_uop(make_uop(uop_pkg::UOP_HLT, none, none, none, 0, 2'd0, 6'b000011, 64'h1044));
        add_row({`DEC_OP_MOVZ, 1'b0, 2'd3, 16'h1234, 5'd8},
                enc_rr(`DEC_OP_ANDS, 5'd1, 5'd1, 5'd1), 2'd1, 64'h1048, 2'b00);
        add_uop(make_uop(uop_pkg::UOP_MOVZ, gpr(8), none, none, 21'h1234, 2'd0, 6'b000111,
                         64'h1048));
        add_row(enc_rr(`DEC_OP_ANDS, 5'd11, 5'd10, 5'd9),
                enc_rr(`DEC_OP_SUBS, 5'd14, 5'd13, 5'd12), 2'd2, 64'h1050, 2'b00);
        add_uop(make_uop(uop_pkg::UOP_AND, gpr(9), gpr(10), gpr(11), 0, 2'd0, 6'b100111, 64'h1050));
        add_uop(make_uop(uop_pkg::UOP_SUB, gpr(12), gpr(13), gpr(14), 0, 2'd0, 6'b100111,
                         64'h1054));

        wait (rst_n === 1'b1);
        @(posedge clk_in);
        #2;
        for (int r = 0; r < nrows; r++)
            offer_row(r, 1'b1);

        ready_mode = 1;
        while (exp_q.size() != 0)
            @(posedge clk_in);
        ready_mode = 2;
        repeat (2) @(posedge clk_in);
        #2;
        // fill output and skid entries, then flush
        offer_row(0, 1'b0);
        offer_row(0, 1'b0);
        if (decode_ready !== 1'b0) begin
            value_errors++;
            $display("CHECK FAILED at %0t: decode_ready high with skid entry full", $time);
        end
        flush = 1'b1;
        @(posedge clk_in);
        #2;
        flush = 1'b0;
        if (out_valid !== 1'b0 || decode_ready !== 1'b1) begin
            value_errors++;
            $display("CHECK FAILED at %0t: buffer not empty after flush", $time);
        end
        ready_mode = 1;
        repeat (4) @(posedge clk_in);

        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%0d expected bundles never came out", exp_q.size());
        end
        assert_errors = i_decode_top.i_issue_buffer.i_decode_properties.fail_count;
        $display("errors: %0d wrong values, %0d other, %0d assertion",
                 value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/decode_properties.sv
`timescale 1ns/100ps
`default_nettype none

module decode_properties (
    input logic             clk_in,
    input logic             rst_n,
    input logic             flush,
    input logic             out_valid,
    input logic             out_ready,
    input uop_pkg::bundle_t out_bundle
);

    int fail_count = 0;  // assertion failures so far

    // async reset clears the output entry
    assert property (@(posedge clk_in) !rst_n |-> !out_valid)
        else begin
            $error("out_valid high during reset");
            fail_count++;
        end

    // stalled bundle must hold, flush is the only way out
    assert property (@(posedge clk_in) disable iff (!rst_n)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_bundle))
        else begin
            $error("output bundle changed while stalled");
            fail_count++;
        end

    assert property (@(posedge clk_in) disable iff (!rst_n)
        out_valid |-> out_bundle.count != '0)
        else begin
            $error("empty bundle presented to execute");
            fail_count++;
        end

endmodule

bind issue_buffer decode_properties i_decode_properties (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .flush     (flush),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_bundle(out_bundle)
);

`default_nettype wire

// File: bench/decode_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module decode_clock_gen (
    output logic clk_in,
    output logic rst_n
);

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;  // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk_in);
        #2 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: hdl/decode_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module decode_top (
    input  logic                     clk_in,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     fetch_valid,
    input  logic [1:0]               fetch_count,
    input  isa_pkg::insn_t           fetch_words [`DEC_FETCH_WIDTH],
    input  logic [`DEC_PC_WIDTH-1:0] fetch_pc,
    input  logic [1:0]               predict_taken,
    output logic                     decode_ready,
    output logic                     out_valid,
    output uop_pkg::bundle_t         out_bundle,
    input  logic                     exe_ready
);

    logic [`DEC_FETCH_WIDTH-1:0] slot_valid;
    uop_pkg::lane_out_t          lane_out [`DEC_FETCH_WIDTH];
    uop_pkg::bundle_t            lane_bundle;

    for (genvar gi = 0; gi < `DEC_FETCH_WIDTH; gi++) begin : g_lane
        assign slot_valid[gi] = (int'(fetch_count) > gi);

        decode_lane #(
            .LANE_INDEX(gi)
        ) i_decode_lane (
            .slot_valid   (slot_valid[gi]),
            .insn         (fetch_words[gi]),
            .base_pc      (fetch_pc),
            .predict_taken(predict_taken[gi]),
            .result       (lane_out[gi])
        );
    end

    bundle_packer i_bundle_packer (
        .lane0 (lane_out[0]),
        .lane1 (lane_out[1]),
        .bundle(lane_bundle)
    );

    // an empty bundle is consumed here without reaching execute
    issue_buffer i_issue_buffer (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (fetch_valid),
        .in_bundle (lane_bundle),
        .in_ready  (decode_ready),
        .out_valid (out_valid),
        .out_bundle(out_bundle),
        .out_ready (exe_ready)
    );

endmodule

`default_nettype wire

// File: hdl/issue_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module issue_buffer (
    input  logic             clk_in,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             in_valid,
    input  uop_pkg::bundle_t in_bundle,
    output logic             in_ready,
    output logic             out_valid,
    output uop_pkg::bundle_t out_bundle,
    input  logic             out_ready
);

    uop_pkg::bundle_t out_q;
    uop_pkg::bundle_t skid_q;
    logic             out_v;
    logic             skid_v;
    logic             keep;      // accepted and holds at least one uop
    logic             out_free;  // output register may load on this edge

    assign in_ready  = ~skid_v;  // low while the skid entry is full
    assign keep      = in_valid & in_ready & (in_bundle.count != '0);
    assign out_free  = ~out_v | out_ready;

    assign out_valid  = out_v;
    assign out_bundle = out_q;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            out_v  <= 1'b0;
            skid_v <= 1'b0;
        end else if (flush) begin
            out_v  <= 1'b0;
            skid_v <= 1'b0;
        end else if (out_free) begin
            // skid drains first; keep is low whenever skid_v is set
            out_v  <= skid_v | keep;
            skid_v <= 1'b0;
        end else if (keep) begin
            skid_v <= 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (out_free) begin
            out_q <= skid_v ? skid_q : in_bundle;
        end
        if (!out_free && keep) begin
            skid_q <= in_bundle;  // output stalled, park the new bundle
        end
    end

endmodule

`default_nettype wire

// File: hdl/bundle_packer.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module bundle_packer (
    input  uop_pkg::lane_out_t lane0,
    input  uop_pkg::lane_out_t lane1,
    output uop_pkg::bundle_t   bundle
);

    localparam int BUNDLE_CNT_W = $clog2(`DEC_BUNDLE_WIDTH + 1);

    logic [BUNDLE_CNT_W-1:0] lane0_count;
    logic [BUNDLE_CNT_W-1:0] lane1_count;  // zero when lane0 ends the bundle

    assign lane0_count = BUNDLE_CNT_W'(lane0.count);
    assign lane1_count = lane0.stop ? '0 : BUNDLE_CNT_W'(lane1.count);

    // lane1 starts right after lane0's last uop, so no gaps
    always_comb begin
        bundle = '0;
        for (int i = 0; i < `DEC_UOPS_PER_INSN; i++) begin
            if (i < int'(lane0_count)) begin
                bundle.uops[i] = lane0.uops[i];
            end
            if (i < int'(lane1_count)) begin
                bundle.uops[int'(lane0_count) + i] = lane1.uops[i];
            end
        end
        bundle.count = lane0_count + lane1_count;
    end

endmodule

`default_nettype wire

// File: hdl/decode_lane.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module decode_lane #(
    parameter int LANE_INDEX = 0
) (
    input  logic                     slot_valid,
    input  isa_pkg::insn_t           insn,
    input  logic [`DEC_PC_WIDTH-1:0] base_pc,
    input  logic                     predict_taken,
    output uop_pkg::lane_out_t       result
);

    isa_pkg::opcode_e         opcode;
    logic [`DEC_PC_WIDTH-1:0] slot_pc;
    logic                     rn_is_sp;
    logic                     rd_is_sp;
    logic                     has_offset;
    uop_pkg::uop_t            blank;   // fields common to every uop of this slot
    uop_pkg::uop_t            first;
    uop_pkg::uop_t            second;  // only a cracked load uses it

    function automatic uop_pkg::uop_code_e alu_code(input isa_pkg::opcode_e op);
        uop_pkg::uop_code_e code;
        case (op)
            isa_pkg::OP_SUB_I, isa_pkg::OP_SUBS: code = uop_pkg::UOP_SUB;
            isa_pkg::OP_ORR:  code = uop_pkg::UOP_ORR;
            isa_pkg::OP_EOR:  code = uop_pkg::UOP_EOR;
            isa_pkg::OP_ANDS: code = uop_pkg::UOP_AND;
            default:          code = uop_pkg::UOP_ADD;
        endcase
        return code;
    endfunction

    assign opcode     = insn.ri.opcode;
    assign slot_pc    = base_pc + `DEC_PC_WIDTH'(4 * LANE_INDEX);
    assign rn_is_sp   = (insn.ri.rn == 5'(`DEC_SP_REG));
    assign rd_is_sp   = (insn.ri.rd == 5'(`DEC_SP_REG));
    assign has_offset = (insn.mem.imm9 != 9'd0);

    always_comb begin
        blank          = '0;
        blank.pc       = slot_pc;
        blank.tx_begin = 1'b1;
        blank.tx_end   = 1'b1;
    end

    always_comb begin
        result = '0;
        first  = blank;
        second = '0;
        if (slot_valid) begin
            case (opcode)
                isa_pkg::OP_ADD_I, isa_pkg::OP_SUB_I: begin
                    first.code        = alu_code(opcode);
                    first.dst.gpr     = insn.ri.rd;
                    first.dst.is_sp   = rd_is_sp & rn_is_sp;
                    first.src1.gpr    = insn.ri.rn;
                    first.src1.is_sp  = rn_is_sp;
                    first.imm         = `DEC_IMM_WIDTH'(insn.ri.imm12);
                    first.w_enable    = 1'b1;
                    result.count      = 2'd1;
                end
                isa_pkg::OP_ADDS, isa_pkg::OP_SUBS, isa_pkg::OP_ORR,
                isa_pkg::OP_EOR, isa_pkg::OP_ANDS: begin
                    first.code     = alu_code(opcode);
                    first.dst.gpr  = insn.rr.rd;
                    first.src1.gpr = insn.rr.rn;
                    first.src2.gpr = insn.rr.rm;
                    first.valb_sel = 1'b1;
                    first.w_enable = 1'b1;
                    result.count   = 2'd1;
                end
                isa_pkg::OP_MOVZ, isa_pkg::OP_MOVK: begin
                    first.code = (opcode == isa_pkg::OP_MOVK) ? uop_pkg::UOP_MOVK
                                                               : uop_pkg::UOP_MOVZ;
                    first.dst.gpr  = insn.mov.rd;
                    first.imm      = `DEC_IMM_WIDTH'(insn.mov.imm16);
                    first.hw       = (opcode == isa_pkg::OP_MOVK) ? insn.mov.hw : 2'b00;
                    first.w_enable = 1'b1;
                    result.count   = 2'd1;
                end
                isa_pkg::OP_LDUR: begin
                    first.dst.gpr    = insn.mem.rd;
                    first.src1.gpr   = insn.mem.rn;
                    first.src1.is_sp = rn_is_sp;
                    first.w_enable   = 1'b1;
                    if (has_offset) begin
                        // address goes into rd, then the load reads it back from rd
                        first.code      = uop_pkg::UOP_ADD;
                        first.imm       = `DEC_IMM_WIDTH'(insn.mem.imm9);
                        first.tx_end    = 1'b0;
                        second          = blank;
                        second.code     = uop_pkg::UOP_LOAD;
                        second.dst.gpr  = insn.mem.rd;
                        second.src1.gpr = insn.mem.rd;
                        second.mem_read = 1'b1;
                        second.w_enable = 1'b1;
                        second.tx_begin = 1'b0;
                        result.count    = 2'd2;
                    end else begin
                        first.code     = uop_pkg::UOP_LOAD;
                        first.mem_read = 1'b1;
                        result.count   = 2'd1;
                    end
                end
                isa_pkg::OP_STUR: begin
                    first.code        = uop_pkg::UOP_STORE;
                    first.src1.gpr    = insn.mem.rn;
                    first.src1.is_sp  = rn_is_sp;
                    first.src2.gpr    = insn.mem.rd;  // store data
                    first.imm         = `DEC_IMM_WIDTH'(insn.mem.imm9);
                    first.mem_write   = 1'b1;
                    result.count      = 2'd1;
                end
                isa_pkg::OP_BCOND: begin
                    first.code   = uop_pkg::UOP_BCOND;
                    result.count = 2'd1;
                    result.stop  = predict_taken;
                end
                isa_pkg::OP_B: result.stop = 1'b1;  // fetch already redirected
                isa_pkg::OP_HLT: begin
                    first.code   = uop_pkg::UOP_HLT;
                    result.count = 2'd1;
                end
                default: begin
                    // nop and unknown opcodes emit nothing
                end
            endcase
        end
        if (result.count != 2'd0) begin
            result.uops[0] = first;
        end
        if (result.count == 2'd2) begin
            result.uops[1] = second;
        end
    end

endmodule

`default_nettype wire

// File: hdl/uop_pkg.sv
`default_nettype none

`include "decode_params.svh"

package uop_pkg;

    typedef enum logic [3:0] {
        UOP_ADD   = 4'd0,
        UOP_SUB   = 4'd1,
        UOP_AND   = 4'd2,
        UOP_ORR   = 4'd3,
        UOP_EOR   = 4'd4,
        UOP_MOVZ  = 4'd5,
        UOP_MOVK  = 4'd6,
        UOP_LOAD  = 4'd7,
        UOP_STORE = 4'd8,
        UOP_BCOND = 4'd9,
        UOP_HLT   = 4'd10
    } uop_code_e;

    typedef struct packed {
        logic [4:0] gpr;
        logic       is_sp;
    } reg_ref_t;

    typedef struct packed {
        uop_code_e                 code;
        reg_ref_t                  dst;
        reg_ref_t                  src1;
        reg_ref_t                  src2;
        logic [`DEC_IMM_WIDTH-1:0] imm;
        logic [1:0]                hw;        // movk lane select
        logic                      valb_sel;  // 1 takes src2, 0 takes imm
        logic                      mem_read;
        logic                      mem_write;
        logic                      w_enable;
        logic                      tx_begin;
        logic                      tx_end;
        logic [`DEC_PC_WIDTH-1:0]  pc;
    } uop_t;

    typedef struct packed {
        uop_t [`DEC_UOPS_PER_INSN-1:0]           uops;
        logic [$clog2(`DEC_UOPS_PER_INSN+1)-1:0] count;
        logic                                    stop;  // later slots are dropped
    } lane_out_t;

    typedef struct packed {
        uop_t [`DEC_BUNDLE_WIDTH-1:0]           uops;
        logic [$clog2(`DEC_BUNDLE_WIDTH+1)-1:0] count;
    } bundle_t;

endpackage

`default_nettype wire

// File: hdl/isa_pkg.sv
`default_nettype none

`include "decode_params.svh"

package isa_pkg;

    typedef enum logic [7:0] {
        OP_ADD_I = `DEC_OP_ADD_I,
        OP_SUB_I = `DEC_OP_SUB_I,
        OP_ADDS  = `DEC_OP_ADDS,
        OP_SUBS  = `DEC_OP_SUBS,
        OP_ORR   = `DEC_OP_ORR,
        OP_EOR   = `DEC_OP_EOR,
        OP_ANDS  = `DEC_OP_ANDS,
        OP_MOVZ  = `DEC_OP_MOVZ,
        OP_MOVK  = `DEC_OP_MOVK,
        OP_LDUR  = `DEC_OP_LDUR,
        OP_STUR  = `DEC_OP_STUR,
        OP_B     = `DEC_OP_B,
        OP_BCOND = `DEC_OP_BCOND,
        OP_NOP   = `DEC_OP_NOP,
        OP_HLT   = `DEC_OP_HLT
    } opcode_e;

    // immediate add and subtract
    typedef struct packed {
        opcode_e     opcode;
        logic [1:0]  rsvd;
        logic [11:0] imm12;
        logic [4:0]  rn;
        logic [4:0]  rd;
    } ri_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  rsvd_hi;
        logic [4:0]  rm;       // bits 20:16
        logic [5:0]  rsvd_lo;
        logic [4:0]  rn;
        logic [4:0]  rd;
    } rr_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic        rsvd;
        logic [1:0]  hw;
        logic [15:0] imm16;
        logic [4:0]  rd;
    } mov_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  rsvd_hi;
        logic [8:0]  imm9;     // bits 20:12
        logic [1:0]  rsvd_lo;
        logic [4:0]  rn;
        logic [4:0]  rd;
    } mem_fmt_t;

    // every view shares the opcode byte and rd in 4:0
    typedef union packed {
        logic [`DEC_INSN_WIDTH-1:0] raw;
        ri_fmt_t  ri;
        rr_fmt_t  rr;
        mov_fmt_t mov;
        mem_fmt_t mem;
    } insn_t;

endpackage

`default_nettype wire

// File: hdl/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

`define DEC_FETCH_WIDTH   2
`define DEC_UOPS_PER_INSN 2
`define DEC_BUNDLE_WIDTH  4
`define DEC_PC_WIDTH      64
`define DEC_INSN_WIDTH    32
`define DEC_IMM_WIDTH     21

// x31 reads as sp in the add and subtract forms
`define DEC_SP_REG        31

// opcode byte, bits 31:24 of the word
`define DEC_OP_ADD_I 8'h91
`define DEC_OP_SUB_I 8'hd1
`define DEC_OP_ADDS  8'hab
`define DEC_OP_SUBS  8'heb
`define DEC_OP_ORR   8'haa
`define DEC_OP_EOR   8'hca
`define DEC_OP_ANDS  8'hea
`define DEC_OP_MOVZ  8'hd2
`define DEC_OP_MOVK  8'hf2
`define DEC_OP_LDUR  8'hf8
`define DEC_OP_STUR  8'hf9
`define DEC_OP_B     8'h14
`define DEC_OP_BCOND 8'h54
`define DEC_OP_NOP   8'hd5
`define DEC_OP_HLT   8'hd4

`endif
